// File: hdl/clio_pkg.sv
// clio control core shared definitions
// register map, interrupt bit positions, timer control fields,
// line timer phase boundaries and the internal bus structs
package clio_pkg;

	typedef logic [31:0] word_t;		// one cpu register word
	typedef logic [13:0] reg_addr_t;	// word address, cpu_addr[15:2]

	// byte offsets within the clio window
	localparam logic [15:0] REG_REVISION       = 16'h0000;
	localparam logic [15:0] REG_VINT0          = 16'h0008;
	localparam logic [15:0] REG_VINT1          = 16'h000C;
	localparam logic [15:0] REG_HCNT           = 16'h0030;	// hpos on read
	localparam logic [15:0] REG_VCNT           = 16'h0034;	// vpos on read
	localparam logic [15:0] REG_IRQ0_SET       = 16'h0040;
	localparam logic [15:0] REG_IRQ0_CLR       = 16'h0044;
	localparam logic [15:0] REG_IRQ0_EN_SET    = 16'h0048;
	localparam logic [15:0] REG_IRQ0_EN_CLR    = 16'h004C;
	localparam logic [15:0] REG_IRQ1_SET       = 16'h0060;
	localparam logic [15:0] REG_IRQ1_CLR       = 16'h0064;
	localparam logic [15:0] REG_IRQ1_EN_SET    = 16'h0068;
	localparam logic [15:0] REG_IRQ1_EN_CLR    = 16'h006C;
	localparam logic [15:0] REG_TIMER_BASE     = 16'h0100;	// count at +8n, backup at +8n+4
	localparam logic [15:0] REG_TIMER_CTRL_SET = 16'h0200;	// low 32 bits of timer_ctrl only
	localparam logic [15:0] REG_TIMER_CTRL_CLR = 16'h0204;

	localparam word_t READ_DEFAULT = 32'hBADA_CCE5;	// unmapped read pattern

	// irq0 bit positions
	localparam int IRQ_VINT0_BIT  = 0;
	localparam int IRQ_VINT1_BIT  = 1;
	localparam int IRQ_TIMER_LSB  = 3;	// timer n -> bit 3+n
	localparam int IRQ_SECOND_BIT = 31;	// irq1 summary

	// timers
	localparam int MAX_TIMERS       = 16;
	localparam int TIMER_CTRL_BITS  = 4;	// per timer nibble in timer_ctrl
	localparam int TCTRL_DEC_BIT    = 0;	// decrement enable
	localparam int TCTRL_RELOAD_BIT = 1;	// reload from backup on underflow

	// line timer, in 25 MHz clocks
	localparam int LINE_CLOCKS = 1800;
	localparam int READ_FIRST  = 11;
	localparam int WRITE_FIRST = 1293;
	localparam int COPY_FIRST  = 1340;
	localparam int HSYNC_FIRST = 1400;

	typedef enum logic [2:0] {
		PH_LEAD,	// start of line, before vram reads
		PH_READ,	// active pixels, blank_n high
		PH_WRITE,
		PH_COPY,
		PH_HSYNC
	} line_phase_e;

	// decoded write, broadcast to every register owner
	typedef struct packed {
		logic      stb;		// one cycle per acked write
		reg_addr_t addr;	// word address
		word_t     data;
	} reg_wr_t;

	// one-cycle hardware event pulses into irq0
	typedef struct packed {
		logic [MAX_TIMERS-1:0] timer;	// unused timers tied low at the top
		logic                  vint1;
		logic                  vint0;
	} irq_event_t;

	// word address back to a byte offset for decoding
	function automatic logic [15:0] byte_off(reg_addr_t addr);
		return {addr, 2'b00};
	endfunction

endpackage

// File: hdl/clio_regs.sv
// clio cpu register window as a wishbone classic slave
// fixed one cycle ack, registered read mux, vint line compare registers
// and the decoded write broadcast to the other register owners
`timescale 1ns/100ps

module clio_regs #(
	parameter int              N_TIMERS = 4,
	parameter clio_pkg::word_t REVISION = 32'h0202_0000
) (
	input  logic                                  clk_25m,
	input  logic                                  rst_n,
	input  logic                                  wb_cyc,
	input  logic                                  wb_stb,
	input  logic                                  wb_we,
	input  clio_pkg::reg_addr_t                   wb_adr,
	input  clio_pkg::word_t                       wb_dat_w,
	input  clio_pkg::word_t                       irq0_rd,
	input  clio_pkg::word_t                       irq0_en_rd,
	input  clio_pkg::word_t                       irq1_rd,
	input  clio_pkg::word_t                       irq1_en_rd,
	input  clio_pkg::word_t [N_TIMERS-1:0]        timer_count_rd,
	input  clio_pkg::word_t [N_TIMERS-1:0]        timer_backup_rd,
	input  logic [11:0]                           hcount,
	input  logic [11:0]                           vcount,
	output clio_pkg::word_t                       wb_dat_r,
	output logic                                  wb_ack,
	output clio_pkg::reg_wr_t                     reg_wr,
	output logic [9:0]                            vint0,
	output logic [9:0]                            vint1
);
	import clio_pkg::*;

	logic        req;		// new request this cycle
	logic [15:0] rd_byte;	// byte offset of the access
	word_t       rd_word;	// read mux output

	// a held request is served once, the ack cycle blocks the repeat
	assign req     = wb_cyc && wb_stb && !wb_ack;
	assign rd_byte = byte_off(wb_adr);

	// write strobe lands on the same edge that raises ack
	assign reg_wr.stb  = req && wb_we;
	assign reg_wr.addr = wb_adr;
	assign reg_wr.data = wb_dat_w;

	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;	// one cycle, never stalls
		end
	end

	// vint0/vint1 only keep the line number bits
	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n) begin
			vint0 <= '0;
			vint1 <= '0;
		end else if (reg_wr.stb) begin
			if (rd_byte == REG_VINT0)
				vint0 <= reg_wr.data[9:0];
			if (rd_byte == REG_VINT1)
				vint1 <= reg_wr.data[9:0];
		end
	end

	always_comb begin
		rd_word = READ_DEFAULT;	// anything unmapped
		case (rd_byte)
			REG_REVISION: rd_word = REVISION;
			REG_VINT0:    rd_word = {22'b0, vint0};
			REG_VINT1:    rd_word = {22'b0, vint1};
			REG_HCNT:     rd_word = {20'b0, hcount};
			REG_VCNT:     rd_word = {20'b0, vcount};
			REG_IRQ0_SET, REG_IRQ0_CLR:       rd_word = irq0_rd;	// pending
			REG_IRQ0_EN_SET, REG_IRQ0_EN_CLR: rd_word = irq0_en_rd;	// mask
			REG_IRQ1_SET, REG_IRQ1_CLR:       rd_word = irq1_rd;
			REG_IRQ1_EN_SET, REG_IRQ1_EN_CLR: rd_word = irq1_en_rd;
			default: begin
				// timer window, count then backup per timer
				for (int n = 0; n < N_TIMERS; n++) begin
					if (rd_byte == REG_TIMER_BASE + 16'(8 * n))
						rd_word = timer_count_rd[n];
					if (rd_byte == REG_TIMER_BASE + 16'(8 * n + 4))
						rd_word = timer_backup_rd[n];
				end
			end
		endcase
	end

	// read data holds until the next request
	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n)
			wb_dat_r <= '0;
		else if (req)
			wb_dat_r <= rd_word;
	end

	// every request gets exactly one ack cycle
	a_ack_single: assert property (
		@(posedge clk_25m) disable iff (!rst_n)
		wb_ack |=> !wb_ack
	) else $error("wishbone ack held for two cycles");

endmodule

// File: hdl/clio_irq.sv
// clio interrupt controller
// two pending/enable banks with set/clear access, hardware events into irq0,
// irq1 summary folded into irq0 bit 31 and the registered firq_n
`timescale 1ns/100ps

module clio_irq (
	input  logic                 clk_25m,
	input  logic                 rst_n,
	input  clio_pkg::reg_wr_t    reg_wr,
	input  clio_pkg::irq_event_t events,
	output clio_pkg::word_t      irq0_rd,
	output clio_pkg::word_t      irq0_en_rd,
	output clio_pkg::word_t      irq1_rd,
	output clio_pkg::word_t      irq1_en_rd,
	output logic                 firq_n
);
	import clio_pkg::*;

	logic [30:0] pend0;			// bit 31 is the irq1 summary, not stored
	word_t       en0, pend1, en1;
	word_t       ev0;			// events placed at their irq0 bits
	logic [15:0] wr_byte;
	logic        irq1_any;		// enabled irq1 pending
	logic        irq_any;		// anything enabled pending

	assign wr_byte = byte_off(reg_wr.addr);

	always_comb begin
		ev0                                   = '0;
		ev0[IRQ_VINT0_BIT]                    = events.vint0;
		ev0[IRQ_VINT1_BIT]                    = events.vint1;
		ev0[IRQ_TIMER_LSB +: MAX_TIMERS]      = events.timer;
	end

	assign irq1_any = |(pend1 & en1);
	assign irq_any  = (|(pend0 & en0[30:0])) || irq1_any;

	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n) begin
			pend0 <= '0;
			en0   <= '0;
			pend1 <= '0;
			en1   <= '0;
		end else begin
			if (reg_wr.stb) begin
				case (wr_byte)
					REG_IRQ0_SET:    pend0 <= pend0 | reg_wr.data[30:0];
					REG_IRQ0_CLR:    pend0 <= pend0 & ~reg_wr.data[30:0];
					REG_IRQ0_EN_SET: en0   <= en0 | reg_wr.data;
					REG_IRQ0_EN_CLR: en0   <= en0 & ~reg_wr.data;
					REG_IRQ1_SET:    pend1 <= pend1 | reg_wr.data;
					REG_IRQ1_CLR:    pend1 <= pend1 & ~reg_wr.data;
					REG_IRQ1_EN_SET: en1   <= en1 | reg_wr.data;
					REG_IRQ1_EN_CLR: en1   <= en1 & ~reg_wr.data;
					default: ;
				endcase
			end
			// events last, so they beat a clear in the same cycle
			if (|ev0[30:0])
				pend0 <= (reg_wr.stb && wr_byte == REG_IRQ0_CLR) ?
				         ((pend0 & ~reg_wr.data[30:0]) | ev0[30:0]) :
				         ((reg_wr.stb && wr_byte == REG_IRQ0_SET) ?
				          (pend0 | reg_wr.data[30:0] | ev0[30:0]) : (pend0 | ev0[30:0]));
		end
	end

	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n)
			firq_n <= 1'b1;
		else
			firq_n <= !irq_any;	// one cycle behind the pending state
	end

	always_comb begin
		irq0_rd                 = {1'b0, pend0};
		irq0_rd[IRQ_SECOND_BIT] = irq1_any;	// irq1 summary
	end

	assign irq0_en_rd = en0;
	assign irq1_rd    = pend1;
	assign irq1_en_rd = en1;

	// firq only follows a real enabled pending bit
	a_firq_cause: assert property (
		@(posedge clk_25m) disable iff (!rst_n)
		!firq_n |-> $past(irq_any)
	) else $error("firq_n low with nothing enabled pending");

endmodule

// File: hdl/clio_timers.sv
// clio timer bank
// down-counters with backup reload, low timer_ctrl word with set/clear
// access and one underflow pulse per timer
`timescale 1ns/100ps

module clio_timers #(
	parameter int N_TIMERS = 4	// low timer_ctrl word covers up to 8
) (
	input  logic                           clk_25m,
	input  logic                           rst_n,
	input  clio_pkg::reg_wr_t              reg_wr,
	output clio_pkg::word_t [N_TIMERS-1:0] timer_count_rd,
	output clio_pkg::word_t [N_TIMERS-1:0] timer_backup_rd,
	output logic [N_TIMERS-1:0]            underflow
);
	import clio_pkg::*;

	localparam int CTRL_W = N_TIMERS * TIMER_CTRL_BITS;

	logic [15:0]       wr_byte;
	logic [CTRL_W-1:0] ctrl;		// one nibble per timer
	word_t             count  [N_TIMERS];
	word_t             backup [N_TIMERS];
	logic [N_TIMERS-1:0] wr_count;	// cpu write to a count register
	logic [N_TIMERS-1:0] wr_backup;

	assign wr_byte = byte_off(reg_wr.addr);

	// timer_ctrl set/clear, upper half not implemented
	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (reg_wr.stb) begin
			if (wr_byte == REG_TIMER_CTRL_SET)
				ctrl <= ctrl | reg_wr.data[CTRL_W-1:0];
			else if (wr_byte == REG_TIMER_CTRL_CLR)
				ctrl <= ctrl & ~reg_wr.data[CTRL_W-1:0];
		end
	end

	for (genvar n = 0; n < N_TIMERS; n++) begin : g_timer
		logic dec_en;		// decrement this cycle
		logic reload_en;

		assign dec_en    = ctrl[n * TIMER_CTRL_BITS + TCTRL_DEC_BIT];
		assign reload_en = ctrl[n * TIMER_CTRL_BITS + TCTRL_RELOAD_BIT];

		assign wr_count[n]  = reg_wr.stb && (wr_byte == REG_TIMER_BASE + 16'(8 * n));
		assign wr_backup[n] = reg_wr.stb && (wr_byte == REG_TIMER_BASE + 16'(8 * n + 4));

		// pulse as the count leaves zero, cpu write cancels the step
		assign underflow[n] = dec_en && !wr_count[n] && (count[n] == '0);

		always_ff @(posedge clk_25m or negedge rst_n) begin
			if (!rst_n) begin
				count[n] <= '0;
			end else if (wr_count[n]) begin
				count[n] <= reg_wr.data;	// cpu beats the decrement
			end else if (dec_en) begin
				if (count[n] == '0 && reload_en)
					count[n] <= backup[n];
				else
					count[n] <= count[n] - 32'd1;	// wraps to all ones
			end
		end

		always_ff @(posedge clk_25m or negedge rst_n) begin
			if (!rst_n)
				backup[n] <= '0;
			else if (wr_backup[n])
				backup[n] <= reg_wr.data;
		end

		assign timer_count_rd[n]  = count[n];
		assign timer_backup_rd[n] = backup[n];

		// a stopped timer only moves on a cpu write
		a_frozen: assert property (
			@(posedge clk_25m) disable iff (!rst_n)
			(!dec_en && !wr_count[n]) |=> (count[n] == $past(count[n]))
		) else $error("timer %0d moved with decrement disabled", n);
	end

endmodule

// File: hdl/clio_video_timing.sv
// clio video line timer
// clocks within a line and lines within a field, the line phase decode,
// blank_n during the vram read phase and the vint line compare events
`timescale 1ns/100ps

module clio_video_timing #(
	parameter int LINES_PER_FIELD = 262
) (
	input  logic        clk_25m,
	input  logic        rst_n,
	input  logic [9:0]  vint0,		// compare line for vint0
	input  logic [9:0]  vint1,
	output logic [11:0] hcount,
	output logic [11:0] vcount,
	output logic        blank_n,
	output logic        vint0_hit,	// one clock at start of matching line
	output logic        vint1_hit
);
	import clio_pkg::*;

	localparam logic [11:0] H_LAST = 12'(LINE_CLOCKS - 1);
	localparam logic [11:0] V_LAST = 12'(LINES_PER_FIELD - 1);

	line_phase_e phase;
	logic        line_end;		// last clock of the line

	assign line_end = (hcount == H_LAST);

	always_ff @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			hcount <= line_end ? 12'd0 : hcount + 12'd1;
			if (line_end)
				vcount <= (vcount == V_LAST) ? 12'd0 : vcount + 12'd1;	// field wrap
		end
	end

	// read, write and copy windows, only read has a visible effect
	always_comb begin
		if (hcount < 12'(READ_FIRST))
			phase = PH_LEAD;
		else if (hcount < 12'(WRITE_FIRST))
			phase = PH_READ;	// 1282 clocks of pixels
		else if (hcount < 12'(COPY_FIRST))
			phase = PH_WRITE;
		else if (hcount < 12'(HSYNC_FIRST))
			phase = PH_COPY;
		else
			phase = PH_HSYNC;
	end

	assign blank_n = (phase == PH_READ);

	// line compares against the low vcount bits zero extended
	assign vint0_hit = (hcount == 12'd0) && (vcount == {2'b00, vint0});
	assign vint1_hit = (hcount == 12'd0) && (vcount == {2'b00, vint1});

	// line counter never runs past the line length
	a_hcount_range: assert property (
		@(posedge clk_25m) disable iff (!rst_n)
		hcount < 12'(LINE_CLOCKS)
	) else $error("hcount out of range %0d", hcount);

endmodule

// File: hdl/clio.sv
// clio control and interrupt core
// joins the wishbone register slave, the interrupt banks, the timer bank
// and the video line timer
`timescale 1ns/100ps

module clio #(
	parameter int             N_TIMERS        = 4,
	parameter int             LINES_PER_FIELD = 262,
	parameter clio_pkg::word_t REVISION        = 32'h0202_0000
) (
	input  logic               clk_25m,
	input  logic               rst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  clio_pkg::reg_addr_t wb_adr,
	input  clio_pkg::word_t    wb_dat_w,
	output clio_pkg::word_t    wb_dat_r,
	output logic               wb_ack,
	output logic               firq_n,	// to the arm
	output logic               blank_n
);
	import clio_pkg::*;

	reg_wr_t                  reg_wr;		// write broadcast
	irq_event_t               events;
	word_t                    irq0_rd, irq0_en_rd;
	word_t                    irq1_rd, irq1_en_rd;
	word_t [N_TIMERS-1:0]     timer_count_rd;
	word_t [N_TIMERS-1:0]     timer_backup_rd;
	logic  [N_TIMERS-1:0]     underflow;
	logic  [11:0]             hcount, vcount;
	logic  [9:0]              vint0, vint1;	// line compare values
	logic                     vint0_hit, vint1_hit;

	// gather the event pulses, spare timer slots stay low
	assign events.vint0 = vint0_hit;
	assign events.vint1 = vint1_hit;
	assign events.timer = MAX_TIMERS'(underflow);

	clio_regs #(.N_TIMERS(N_TIMERS), .REVISION(REVISION)) u_regs (
		.clk_25m, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.irq0_rd, .irq0_en_rd, .irq1_rd, .irq1_en_rd,
		.timer_count_rd, .timer_backup_rd,
		.hcount, .vcount,
		.wb_dat_r, .wb_ack, .reg_wr,
		.vint0, .vint1
	);

	clio_irq u_irq (
		.clk_25m, .rst_n,
		.reg_wr, .events,
		.irq0_rd, .irq0_en_rd, .irq1_rd, .irq1_en_rd,
		.firq_n
	);

	clio_timers #(.N_TIMERS(N_TIMERS)) u_timers (
		.clk_25m, .rst_n,
		.reg_wr,
		.timer_count_rd, .timer_backup_rd,
		.underflow
	);

	clio_video_timing #(.LINES_PER_FIELD(LINES_PER_FIELD)) u_video (
		.clk_25m, .rst_n,
		.vint0, .vint1,
		.hcount, .vcount,
		.blank_n,
		.vint0_hit, .vint1_hit
	);

endmodule

// File: tests/tb_clio_bus.svh
// wishbone classic master tasks for the clio testbench
// one request at a time, ack awaited with a 10 cycle timeout,
// plus the failure reporters used by the checks
`ifndef TB_CLIO_BUS_SVH
`define TB_CLIO_BUS_SVH

task automatic report_mismatch(input string name, input word_t exp, input word_t act);
	$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
	$display("=== FAIL ===");
	$fatal(1, "value mismatch in %s", name);
endtask

task automatic stop_with_error(input string what);
	$display("%s", what);	// plain description of the failure
	$display("=== FAIL ===");
	$fatal(1, "run aborted");
endtask

// always step at least one edge, so a leftover ack is never taken
task automatic wait_ack(output logic seen);
	int waited;
	waited = 0;
	seen = 1'b0;
	while (!seen && waited < 10) begin
		@(posedge clk_25m);
		#2;				// ack is settled by now
		waited++;
		seen = wb_ack;
	end
endtask

task automatic release_bus();
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
endtask

task automatic wb_write(input logic [15:0] off, input word_t data);
	logic seen;
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = 1'b1;
	wb_adr   = off[15:2];	// byte offset to word address
	wb_dat_w = data;
	wait_ack(seen);
	release_bus();
	if (!seen)
		stop_with_error($sformatf("no wishbone ack for write to offset 0x%h", off));
endtask

task automatic wb_read(input logic [15:0] off, output word_t data);
	logic seen;
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we  = 1'b0;
	wb_adr = off[15:2];
	wait_ack(seen);
	release_bus();
	data = wb_dat_r;		// valid while ack is high
	if (!seen)
		stop_with_error($sformatf("no wishbone ack for read of offset 0x%h", off));
endtask

`endif

// File: tests/tb_clio.sv
// clio testbench
// walks the register window through reset, irq banks, timer underflow,
// line compare and blanking, with concurrent assertions doing the checks
`timescale 1ns/100ps

module tb_clio;
	import clio_pkg::*;

	localparam int LINES        = 8;			// short field, quick vint events
	localparam int FIELD_CLOCKS = LINES * 1800;

	logic      clk_25m;
	logic      rst_n;
	logic      wb_cyc, wb_stb, wb_we;
	reg_addr_t wb_adr;
	word_t     wb_dat_w, wb_dat_r;
	logic      wb_ack, firq_n, blank_n;

	int        cycles = 0;		// free running edge count
	word_t     rng_state;
	logic      rd_check;		// read value handed to a_read_value
	string     rd_name;
	word_t     rd_exp, rd_act, rd_mask;
	logic      firq_check, firq_exp;
	string     firq_name;
	logic      cnt_check;
	word_t     cnt_val;
	int        blank_len, blank_runs;	// current high run, finished runs

	clio #(.LINES_PER_FIELD(LINES)) dut (
		.clk_25m, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack,
		.firq_n, .blank_n
	);

	`include "tb_clio_bus.svh"

	initial begin
		clk_25m = 1'b0;
		forever #10 clk_25m = ~clk_25m;	// 50 MHz bench clock, 20 ns
	end

	always @(posedge clk_25m)
		cycles <= cycles + 1;

	// high run length of blank_n, counted per edge
	always @(posedge clk_25m or negedge rst_n) begin
		if (!rst_n) begin
			blank_len  <= 0;
			blank_runs <= 0;
		end else if (blank_n) begin
			blank_len <= blank_len + 1;
		end else begin
			if (blank_len != 0)
				blank_runs <= blank_runs + 1;
			blank_len <= 0;
		end
	end

	function automatic word_t next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// firq_n low while any enabled bit is pending
	function automatic logic firq_level(word_t pend, word_t en);
		return !(|(pend & en));
	endfunction

	task automatic check_read(input string name, input logic [15:0] off,
			input word_t exp, input word_t mask);
		word_t data;
		wb_read(off, data);
		rd_name  = name;
		rd_exp   = exp;
		rd_act   = data;
		rd_mask  = mask;
		rd_check = 1'b1;
		@(posedge clk_25m);
		#2;
		rd_check = 1'b0;
	endtask

	// one edge for the registered firq_n, checked at the next
	task automatic expect_firq(input string name, input logic exp);
		@(posedge clk_25m);
		#2;
		firq_name  = name;
		firq_exp   = exp;
		firq_check = 1'b1;
		@(posedge clk_25m);
		#2;
		firq_check = 1'b0;
	endtask

	task automatic poll_irq0(input int bit_idx, input int limit, input string what);
		int    start;
		word_t data;
		start = cycles;
		data  = '0;
		while (!data[bit_idx] && (cycles - start) < limit)
			wb_read(REG_IRQ0_SET, data);
		if (!data[bit_idx])
			stop_with_error(what);
	endtask

	a_read_value: assert property (@(posedge clk_25m) disable iff (!rst_n)
		rd_check |-> ((rd_act & rd_mask) == (rd_exp & rd_mask)))
		else report_mismatch(rd_name, rd_exp & rd_mask, rd_act & rd_mask);

	a_firq_level: assert property (@(posedge clk_25m) disable iff (!rst_n)
		firq_check |-> (firq_n == firq_exp))
		else report_mismatch(firq_name, {31'b0, firq_exp}, {31'b0, $sampled(firq_n)});

	a_count_bound: assert property (@(posedge clk_25m) disable iff (!rst_n)
		cnt_check |-> (cnt_val <= 32'd40))
		else report_mismatch("timer 1 count at most", 32'd40, cnt_val);

	a_blank_run: assert property (@(posedge clk_25m) disable iff (!rst_n)
		$fell(blank_n) |-> (blank_len == 1282))
		else report_mismatch("blank_n high run", 32'd1282, word_t'($sampled(blank_len)));

	initial begin
		word_t w, m, first;
		int    b;
		rng_state  = 32'd52652;
		rst_n      = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		rd_check   = 1'b0;
		rd_name    = "";
		rd_exp     = '0;
		rd_act     = '0;
		rd_mask    = '0;
		firq_check = 1'b0;
		firq_exp   = 1'b1;
		firq_name  = "";
		cnt_check  = 1'b0;
		cnt_val    = '0;
		repeat (16) @(posedge clk_25m);
		#2;
		rst_n = 1'b1;

		expect_firq("firq after reset", 1'b1);
		check_read("revision", REG_REVISION, 32'h0202_0000, '1);
		check_read("unmapped 0x10", 16'h0010, 32'hBADA_CCE5, '1);
		check_read("unmapped 0x300", 16'h0300, 32'hBADA_CCE5, '1);

		// park both line compares past the field, drop the reset time hits
		wb_write(REG_VINT0, 32'h0000_03FF);
		wb_write(REG_VINT1, 32'h0000_03FF);
		wb_write(REG_IRQ0_CLR, '1);

		w = next_random();
		wb_write(REG_IRQ0_SET, w);
		check_read("irq0 set readback", REG_IRQ0_SET, w, 32'h7FFF_FFFF);
		for (int k = 0; k < 3; k++) begin
			m = (k == 0) ? next_random() : ((k == 1) ? ~w : w);	// random, disjoint, full
			m = m & 32'h7FFF_FF80;				// keep event and timer bits off
			wb_write(REG_IRQ0_EN_CLR, '1);
			wb_write(REG_IRQ0_EN_SET, m);
			expect_firq("firq from irq0 mask", firq_level(w & 32'h7FFF_FFFF, m));
		end
		wb_write(REG_IRQ0_CLR, w);
		check_read("irq0 after clear", REG_IRQ0_SET, 32'h0, '1);
		expect_firq("firq after irq0 clear", 1'b1);

		b = int'(next_random() & 32'h1F);
		wb_write(REG_IRQ1_SET, 32'd1 << b);
		wb_write(REG_IRQ1_EN_SET, 32'd1 << b);
		check_read("irq1 summary set", REG_IRQ0_SET, 32'h8000_0000, 32'h8000_0000);
		expect_firq("firq from irq1", 1'b0);
		wb_write(REG_IRQ1_EN_CLR, '1);
		check_read("irq1 summary clear", REG_IRQ0_SET, 32'h0, 32'h8000_0000);
		expect_firq("firq after irq1 disable", 1'b1);
		wb_write(REG_IRQ1_CLR, '1);
		wb_write(REG_IRQ0_EN_CLR, '1);

		// timer 1 sits at base+8, backup at base+12
		wb_write(REG_TIMER_BASE + 16'h000C, 32'd40);
		wb_write(REG_TIMER_BASE + 16'h0008, 32'd40);
		wb_write(REG_TIMER_CTRL_SET, 32'h0000_0030);	// decrement and reload
		poll_irq0(4, 100, "timer 1 underflow did not reach irq0 within 100 cycles");
		wb_read(REG_TIMER_BASE + 16'h0008, first);
		cnt_val   = first;
		cnt_check = 1'b1;
		@(posedge clk_25m);
		#2;
		cnt_check = 1'b0;
		wb_write(REG_TIMER_CTRL_CLR, 32'h0000_0030);
		wb_read(REG_TIMER_BASE + 16'h0008, first);
		check_read("timer 1 frozen", REG_TIMER_BASE + 16'h0008, first, '1);
		wb_write(REG_IRQ0_CLR, '1);

		wb_write(REG_VINT0, 32'd3);
		wb_write(REG_IRQ0_EN_SET, 32'h0000_0001);
		poll_irq0(0, 2 * FIELD_CLOCKS, "vint0 did not reach irq0 within two fields");
		check_read("vcount at vint0", REG_VCNT, 32'd3, '1);
		expect_firq("firq from vint0", 1'b0);

		if (blank_runs < 2) begin
			stop_with_error("blank_n showed fewer than two complete high runs");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// File: build.f
+incdir+tests
hdl/clio_pkg.sv
hdl/clio_regs.sv
hdl/clio_irq.sv
hdl/clio_timers.sv
hdl/clio_video_timing.sv
hdl/clio.sv
tests/tb_clio.sv

// File: run.sh
#!/usr/bin/env bash
# build the clio testbench with verilator and run it
# exit status follows the simulation result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module tb_clio -Mdir obj_dir -f build.f &&
./obj_dir/Vtb_clio ||
{ echo "clio simulation failed"; exit 1; }

echo "clio simulation finished"
